// ==== filelist.f ====
concat_cfg_pkg.sv
concat_types_pkg.sv
branch_input_stage.sv
line_buffer.sv
concat_merge.sv
cnn_concat_top.sv
cnn_concat_sva.sv
tb_cnn_concat.sv

// ==== Bender.yml ====
package:
  name: cnn_concat

sources:
  - concat_cfg_pkg.sv
  - concat_types_pkg.sv
  - branch_input_stage.sv
  - line_buffer.sv
  - concat_merge.sv
  - cnn_concat_top.sv
  - target: test
    files:
      - cnn_concat_sva.sv
      - tb_cnn_concat.sv

// ==== tb_cnn_concat.sv ====
`timescale 1ns/1ps

module tb_cnn_concat
  import concat_cfg_pkg::*;
  import concat_types_pkg::*;
();

  localparam int NUM_LAUNCHES   = 7;
  localparam int TOTAL_BEATS    = NUM_BRANCHES * FRAME_BEATS;
  localparam int TIMEOUT_CYCLES = NUM_LAUNCHES * (TOTAL_BEATS + 60) + 200;
  localparam int PLAN_CYCLES    = TIMEOUT_CYCLES;
  localparam int ARRIVE [NUM_BRANCHES] = '{
    ARRIVE_OFFSET_0, ARRIVE_OFFSET_1, ARRIVE_OFFSET_2, ARRIVE_OFFSET_3, ARRIVE_OFFSET_4
  };

  logic          clk;
  logic          reset;
  branch_beats_t branch_in;
  feature_beat_t concat_out;
  logic          frame_done;
  logic          collision;
  overrun_t      overrun;

  // Input beats per branch and cycle, and the expected response per cycle
  feature_beat_t drive_plan [NUM_BRANCHES][PLAN_CYCLES];
  feature_beat_t exp_out [PLAN_CYCLES];
  logic          exp_done [PLAN_CYCLES];
  logic          exp_coll [PLAN_CYCLES];
  overrun_t      exp_ovr [PLAN_CYCLES];

  logic [15:0] lfsr_state = 16'd61;
  int          plan_end;
  int          done_total;
  int          coll_total;

  cnn_concat_top #(
    .FRAME_BEATS (FRAME_BEATS)
  ) cnn_concat_top_i (
    .clk        (clk),
    .reset      (reset),
    .branch_in  (branch_in),
    .concat_out (concat_out),
    .frame_done (frame_done),
    .collision  (collision),
    .overrun    (overrun)
  );

  bind concat_merge cnn_concat_sva cnn_concat_sva_i (
    .clk        (clk),
    .reset      (reset),
    .seg_beats  (seg_beats),
    .concat_out (concat_out),
    .frame_done (frame_done),
    .collision  (collision)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Random data and stimulus plan
  //////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  function automatic logic [31:0] random_bits(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // Alignment delay for segment s
  function automatic int seg_depth(input int s);
    return s * FRAME_BEATS + ARRIVE[0] - ARRIVE[s];
  endfunction

  task automatic schedule_run(input int b, input int start, input int len);
    for (int i = 0; i < len; i++) begin
      drive_plan[b][start+i].valid = 1'b1;
      drive_plan[b][start+i].data  = random_bits(DATA_WIDTH);
    end
  endtask

  // early3 moves branch 3 ahead of its slot
  task automatic launch_concat(input int start, input int early3);
    int t;
    for (int s = 0; s < NUM_BRANCHES; s++) begin
      t = start + ARRIVE[s];
      if (s == 3) begin
        t = t - early3;
      end
      schedule_run(s, t, FRAME_BEATS);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  task automatic build_model();
    int       hits;
    int       beats;
    int       t;
    int       run [NUM_BRANCHES];
    overrun_t ovr;
    beats      = 0;
    ovr        = '0;
    done_total = 0;
    coll_total = 0;
    for (int b = 0; b < NUM_BRANCHES; b++) begin
      run[b] = 0;
    end
    for (int c = 0; c < PLAN_CYCLES; c++) begin
      exp_out[c]  = '0;
      exp_done[c] = 1'b0;
      hits        = 0;
      // Lowest segment with a beat due in this cycle wins
      for (int s = 0; s < NUM_BRANCHES; s++) begin
        t = c - 2 - seg_depth(s);
        if (t >= 0 && drive_plan[s][t].valid) begin
          if (hits == 0) begin
            exp_out[c] = drive_plan[s][t];
          end
          hits++;
        end
      end
      exp_coll[c] = (hits > 1);
      if (hits > 1) begin
        coll_total++;
      end
      if (exp_out[c].valid) begin
        beats++;
        if (beats == TOTAL_BEATS) begin
          exp_done[c] = 1'b1;
          done_total++;
          beats = 0;
        end
      end
      // Overrun flag shows up one cycle after the extra beat
      exp_ovr[c] = ovr;
      for (int b = 0; b < NUM_BRANCHES; b++) begin
        if (!drive_plan[b][c].valid) begin
          run[b] = 0;
        end else if (run[b] == FRAME_BEATS) begin
          ovr[b] = 1'b1;
        end else begin
          run[b]++;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_failure();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_beat(input string name, input feature_beat_t act,
                            input feature_beat_t exp, input int n);
    if (exp.valid && !act.valid) begin
      $display("Expected %s beat with data %h did not arrive in cycle %0d",
               name, exp.data, n);
      stop_on_failure();
    end else if (act.valid !== exp.valid || (exp.valid && act.data !== exp.data)) begin
      $display("FAILED %s in cycle %0d: got %h expected %h", name, n, act, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp,
                            input int n);
    if (act !== exp) begin
      $display("FAILED %s in cycle %0d: got %h expected %h", name, n, act, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_overrun(input overrun_t act, input overrun_t exp, input int n);
    if (act !== exp) begin
      $display("FAILED overrun in cycle %0d: got %h expected %h", n, act, exp);
      stop_on_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int start;
    reset     = 1'b1;
    branch_in = '0;
    for (int b = 0; b < NUM_BRANCHES; b++) begin
      for (int c = 0; c < PLAN_CYCLES; c++) begin
        drive_plan[b][c] = '0;
      end
    end
    // Single launch, then four more with random spacing
    start = 10;
    launch_concat(start, 0);
    for (int k = 0; k < 4; k++) begin
      start = start + 90 + int'(random_bits(4));
      launch_concat(start, 0);
    end
    // Branch 3 one cycle early
    start = start + 90 + int'(random_bits(4));
    launch_concat(start, 1);
    // Branch 2 alone with one beat too many
    start = start + 90 + int'(random_bits(4));
    schedule_run(2, start, FRAME_BEATS + 1);
    plan_end = start + TOTAL_BEATS + 20;
    build_model();

    repeat (8) @(negedge clk);
    reset = 1'b0;
    for (int n = 0; n < plan_end; n++) begin
      check_beat("concat_out", concat_out, exp_out[n], n);
      check_flag("frame_done", frame_done, exp_done[n], n);
      check_flag("collision", collision, exp_coll[n], n);
      check_overrun(overrun, exp_ovr[n], n);
      for (int b = 0; b < NUM_BRANCHES; b++) begin
        branch_in[b] = drive_plan[b][n];
      end
      @(negedge clk);
    end

    if (done_total == 0 || coll_total == 0) begin
      $display("Stimulus produced %0d frame_done pulses and %0d collisions in the model",
               done_total, coll_total);
      $display("Simulation FAILED");
      $fatal(1);
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

  // Watchdog
  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the output stream never finished", cycles);
    stop_on_failure();
  end

endmodule

// ==== cnn_concat_sva.sv ====
`timescale 1ns/1ps

module cnn_concat_sva
  import concat_cfg_pkg::*;
  import concat_types_pkg::*;
(
  input logic          clk,
  input logic          reset,
  input branch_beats_t seg_beats,
  input feature_beat_t concat_out,
  input logic          frame_done,
  input logic          collision
);

  logic [NUM_BRANCHES-1:0] seg_valid;

  always_comb begin
    for (int s = 0; s < NUM_BRANCHES; s++) begin
      seg_valid[s] = seg_beats[s].valid;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Merge output rules
  //////////////////////////////////////////////////////////////////////

  // Collision only after an overlap at the merge input
  collision_has_cause: assert property (
    @(posedge clk) disable iff (reset)
    collision |-> $countones($past(seg_valid)) > 1
  ) else $error("collision raised without two valid segments");

  frame_done_on_beat: assert property (
    @(posedge clk) disable iff (reset)
    frame_done |-> concat_out.valid
  ) else $error("frame_done raised without an output beat");

  // Second reset cycle onward, registers are cleared by then
  quiet_in_reset: assert property (
    @(posedge clk)
    (reset ##1 reset) |-> !concat_out.valid && !frame_done && !collision
  ) else $error("merge output active during reset");

endmodule

// ==== cnn_concat_top.sv ====
`timescale 1ns/1ps

module cnn_concat_top
  import concat_cfg_pkg::*;
  import concat_types_pkg::*;
#(
  parameter int FRAME_BEATS = concat_cfg_pkg::FRAME_BEATS
) (
  input  logic          clk,
  input  logic          reset,
  input  branch_beats_t branch_in,
  output feature_beat_t concat_out,
  output logic          frame_done,
  output logic          collision,
  output overrun_t      overrun
);

  // Delay per segment, segment 0 has none
  localparam int SEG_DEPTH [1:NUM_BRANCHES-1] = '{
    SEG_DEPTH_1, SEG_DEPTH_2, SEG_DEPTH_3, SEG_DEPTH_4
  };

  branch_beats_t reg_beats;
  branch_beats_t delayed_beats;

  //////////////////////////////////////////////////////////////////////
  // Input registers and overrun check
  //////////////////////////////////////////////////////////////////////

  branch_input_stage #(
    .FRAME_BEATS (FRAME_BEATS)
  ) branch_input_stage_i (
    .clk       (clk),
    .reset     (reset),
    .branch_in (branch_in),
    .reg_beats (reg_beats),
    .overrun   (overrun)
  );

  //////////////////////////////////////////////////////////////////////
  // Alignment delays
  //////////////////////////////////////////////////////////////////////

  assign delayed_beats[0] = reg_beats[0];

  for (genvar s = 1; s < NUM_BRANCHES; s++) begin : g_seg
    line_buffer #(
      .payload_t (feature_beat_t),
      .DEPTH     (SEG_DEPTH[s])
    ) line_buffer_i (
      .clk      (clk),
      .reset    (reset),
      .data_in  (reg_beats[s]),
      .data_out (delayed_beats[s])
    );
  end

  // Merge onto one stream
  concat_merge #(
    .FRAME_BEATS (FRAME_BEATS)
  ) concat_merge_i (
    .clk        (clk),
    .reset      (reset),
    .seg_beats  (delayed_beats),
    .concat_out (concat_out),
    .frame_done (frame_done),
    .collision  (collision)
  );

endmodule

// ==== concat_merge.sv ====
`timescale 1ns/1ps

module concat_merge
  import concat_cfg_pkg::*;
  import concat_types_pkg::*;
#(
  parameter int FRAME_BEATS = concat_cfg_pkg::FRAME_BEATS
) (
  input  logic          clk,
  input  logic          reset,
  input  branch_beats_t seg_beats,
  output feature_beat_t concat_out,
  output logic          frame_done,
  output logic          collision
);

  // Beats in one full concatenation
  localparam int TOTAL_BEATS = NUM_BRANCHES * FRAME_BEATS;
  localparam int COUNT_W     = $clog2(TOTAL_BEATS);

  feature_beat_t      sel_beat;
  logic               any_valid;
  logic               multi_valid;
  logic [COUNT_W-1:0] beat_count;
  logic               last_beat;

  //////////////////////////////////////////////////////////////////////
  // Fixed priority select, lowest segment wins
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    sel_beat    = '0;
    any_valid   = 1'b0;
    multi_valid = 1'b0;
    for (int s = 0; s < NUM_BRANCHES; s++) begin
      if (seg_beats[s].valid) begin
        if (any_valid) begin
          // Overlap, this beat is dropped
          multi_valid = 1'b1;
        end else begin
          sel_beat = seg_beats[s];
        end
        any_valid = 1'b1;
      end
    end
  end

  assign last_beat = (beat_count == COUNT_W'(TOTAL_BEATS - 1));

  //////////////////////////////////////////////////////////////////////
  // Output register and beat counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      concat_out.valid <= 1'b0;
      frame_done       <= 1'b0;
      collision        <= 1'b0;
      beat_count       <= '0;
    end else begin
      concat_out <= sel_beat;
      collision  <= multi_valid;
      // frame_done lines up with the last output beat
      frame_done <= any_valid && last_beat;
      if (any_valid) begin
        beat_count <= last_beat ? '0 : beat_count + 1'b1;
      end
    end
  end

endmodule

// ==== line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t data_in,
  output payload_t data_out
);

  //////////////////////////////////////////////////////////////////////
  // Fixed delay line moving the payload one stage per cycle
  //////////////////////////////////////////////////////////////////////

  generate
    if (DEPTH == 0) begin : g_bypass
      // Undelayed use
      assign data_out = data_in;
    end else begin : g_delay
      payload_t stages [DEPTH];

      always_ff @(posedge clk) begin
        if (reset) begin
          // Clear every stage
          for (int i = 0; i < DEPTH; i++) begin
            stages[i] <= '0;
          end
        end else begin
          stages[0] <= data_in;
          for (int i = 1; i < DEPTH; i++) begin
            stages[i] <= stages[i-1];
          end
        end
      end

      assign data_out = stages[DEPTH-1];
    end
  endgenerate

endmodule

// ==== branch_input_stage.sv ====
`timescale 1ns/1ps

module branch_input_stage
  import concat_cfg_pkg::*;
  import concat_types_pkg::*;
#(
  parameter int FRAME_BEATS = concat_cfg_pkg::FRAME_BEATS
) (
  input  logic          clk,
  input  logic          reset,
  input  branch_beats_t branch_in,
  output branch_beats_t reg_beats,
  output overrun_t      overrun
);

  // Wide enough to hold FRAME_BEATS itself
  localparam int RUN_W = $clog2(FRAME_BEATS + 1);

  logic [RUN_W-1:0] run_count [NUM_BRANCHES];

  //////////////////////////////////////////////////////////////////////
  // Input register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int b = 0; b < NUM_BRANCHES; b++) begin
        reg_beats[b].valid <= 1'b0;
      end
    end else begin
      reg_beats <= branch_in;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Run length check per branch
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int b = 0; b < NUM_BRANCHES; b++) begin
        run_count[b] <= '0;
      end
      overrun <= '0;
    end else begin
      for (int b = 0; b < NUM_BRANCHES; b++) begin
        // A gap in valid ends the run
        if (!branch_in[b].valid) begin
          run_count[b] <= '0;
        end else if (run_count[b] != RUN_W'(FRAME_BEATS)) begin
          run_count[b] <= run_count[b] + 1'b1;
        end
        // Beat past a full frame, held until reset
        if (branch_in[b].valid && run_count[b] == RUN_W'(FRAME_BEATS)) begin
          overrun[b] <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== concat_types_pkg.sv ====
package concat_types_pkg;

  import concat_cfg_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Stream payload shared by every block
  //////////////////////////////////////////////////////////////////////

  // One beat on a branch or on the merged stream
  typedef struct packed {
    logic                  valid;
    logic [DATA_WIDTH-1:0] data;
  } feature_beat_t;

  // All branches side by side, index is branch or segment number
  typedef feature_beat_t [NUM_BRANCHES-1:0] branch_beats_t;

  // One sticky flag per branch
  typedef logic [NUM_BRANCHES-1:0] overrun_t;

endpackage

// ==== concat_cfg_pkg.sv ====
package concat_cfg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Beat and feature map geometry
  //////////////////////////////////////////////////////////////////////

  localparam int DATA_WIDTH   = 32;
  localparam int IMAGE_WIDTH  = 4;
  localparam int IMAGE_HEIGHT = 2;
  localparam int CHANNELS     = 2;

  // One branch frame is a full feature map
  localparam int FRAME_BEATS  = IMAGE_WIDTH * IMAGE_HEIGHT * CHANNELS;
  localparam int NUM_BRANCHES = 5;

  //////////////////////////////////////////////////////////////////////
  // Branch arrival, in cycles after branch 0's first beat
  //////////////////////////////////////////////////////////////////////

  localparam int ARRIVE_OFFSET_0 = 0;
  localparam int ARRIVE_OFFSET_1 = 3;
  localparam int ARRIVE_OFFSET_2 = 7;
  localparam int ARRIVE_OFFSET_3 = 2;
  localparam int ARRIVE_OFFSET_4 = 11;

  // Delay that puts segment s right behind segment s-1
  localparam int SEG_DEPTH_1 = 1 * FRAME_BEATS + ARRIVE_OFFSET_0 - ARRIVE_OFFSET_1;
  localparam int SEG_DEPTH_2 = 2 * FRAME_BEATS + ARRIVE_OFFSET_0 - ARRIVE_OFFSET_2;
  localparam int SEG_DEPTH_3 = 3 * FRAME_BEATS + ARRIVE_OFFSET_0 - ARRIVE_OFFSET_3;
  localparam int SEG_DEPTH_4 = 4 * FRAME_BEATS + ARRIVE_OFFSET_0 - ARRIVE_OFFSET_4;

endpackage
